// File: files.f
+incdir+rtl
+incdir+verification
rtl/pmp_checker_pkg.sv
rtl/rvfi_decode_stage.sv
rtl/pmp_match_stage.sv
rtl/violation_check_stage.sv
rtl/pmp_rvfi_checker.sv
verification/tb_pmp_rvfi_checker.sv

// File: Makefile
# Verilator build and run for the PMP retire-trace checker

TOOL       := verilator
TOP        := tb_pmp_rvfi_checker
FILELIST   := files.f
LINT_FLAGS := --lint-only -Wall -Wno-fatal --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The log decides the result, the run itself may end in either state
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/pmp_ref_model.svh
// PMP reference model for the retire-trace checker testbench
// Computes the expected violation mask of one retire from the PMP
// rules, using the cfg and address values of the last valid retire
`ifndef PMP_REF_MODEL_SVH
`define PMP_REF_MODEL_SVH

// Lock history, taken from the last valid retire
logic [`PMPC_NUM_REGIONS*8-1:0]  last_cfg;
logic [`PMPC_NUM_REGIONS*32-1:0] last_addr;

// Value a cfg byte takes after a write attempt
function automatic logic [7:0] legal_cfg_value(
  input logic [7:0] old_cfg,
  input logic [7:0] new_cfg
);
  logic [7:0] res;
  if (old_cfg[7]) begin
    res = old_cfg;
  end else if (new_cfg[1:0] == 2'b10) begin
    // W without R is reserved
    res = {new_cfg[7:3], old_cfg[2:0]};
  end else begin
    res = new_cfg;
  end
  res[6:5] = 2'b00;
  return res;
endfunction

// PMP permission of one access, perm is the cfg bit index (X=2, W=1, R=0)
function automatic logic access_permitted(
  input logic [31:0]                     addr,
  input logic                            m_mode,
  input logic [`PMPC_NUM_REGIONS*8-1:0]  cfg_vec,
  input logic [`PMPC_NUM_REGIONS*32-1:0] addr_vec,
  input int                              perm
);
  logic [33:0] byte_addr;
  logic [33:0] lo_b;
  logic [33:0] hi_b;
  logic [31:0] pmpaddr;
  logic [7:0]  cfg;
  int          ones;
  logic        hit;
  logic        found;
  logic        ok;
  byte_addr = {2'b00, addr};
  lo_b      = '0;
  found     = 1'b0;
  ok        = m_mode;
  for (int i = 0; i < `PMPC_NUM_REGIONS; i++) begin
    cfg     = cfg_vec[i*8 +: 8];
    pmpaddr = addr_vec[i*32 +: 32];
    hi_b    = {pmpaddr, 2'b00};
    ones    = 0;
    for (int b = 0; b < 32; b++) begin
      if (pmpaddr[b] && (ones == b)) begin
        ones++;
      end
    end
    case (cfg[4:3])
      2'b01:   hit = (byte_addr >= lo_b) && (byte_addr < hi_b);
      2'b10:   hit = (byte_addr[33:2] == pmpaddr);
      // Block of 2^(ones+3) bytes
      2'b11:   hit = ((byte_addr >> (ones + 3)) == (hi_b >> (ones + 3)));
      default: hit = 1'b0;
    endcase
    if (hit && !found) begin
      found = 1'b1;
      ok    = cfg[perm] || (m_mode && !cfg[7]);
    end
    lo_b = hi_b;
  end
  return ok;
endfunction

function automatic logic pmp_csr_access(input logic [31:0] insn);
  logic [11:0] csr;
  csr = insn[31:20];
  return (insn[6:0] == 7'h73) && (insn[14:12] != 3'b000) &&
         (csr >= `PMPC_CSR_FIRST) && (csr <= `PMPC_CSR_LAST);
endfunction

function automatic logic [6:0] expected_mask(
  input logic [31:0]                     insn,
  input logic [1:0]                      mode,
  input logic                            trap,
  input logic [5:0]                      cause,
  input logic [31:0]                     pc,
  input logic [31:0]                     mem_addr,
  input logic [`PMPC_NUM_REGIONS*8-1:0]  cfg_r,
  input logic [`PMPC_NUM_REGIONS*8-1:0]  cfg_w,
  input logic [`PMPC_NUM_REGIONS*8-1:0]  cfg_m,
  input logic [`PMPC_NUM_REGIONS*32-1:0] addr_r
);
  logic [6:0] m;
  logic       is_m;
  logic       ld;
  logic       st;
  logic       fetch_ok;
  logic       data_ok;
  is_m     = (mode == `PMPC_MODE_M);
  ld       = (insn[6:0] == 7'h03);
  st       = (insn[6:0] == 7'h23);
  fetch_ok = access_permitted(pc, is_m, cfg_r, addr_r, 2);
  data_ok  = access_permitted(mem_addr, is_m, cfg_r, addr_r, st ? 1 : 0);
  m        = '0;
  m[0] = pmp_csr_access(insn) && (mode == `PMPC_MODE_U) &&
         !(trap && (cause == `PMPC_EXC_ILL_INSTR));
  m[1] = !fetch_ok && !trap;
  m[2] = !fetch_ok && trap && (cause != `PMPC_EXC_INSTR_ACC);
  m[3] = (ld || st) && !data_ok && !trap;
  m[4] = (ld && !data_ok && trap && (cause != `PMPC_EXC_LOAD_ACC)) ||
         (st && !data_ok && trap && (cause != `PMPC_EXC_STORE_ACC));
  for (int i = 0; i < `PMPC_NUM_REGIONS; i++) begin
    if ((cfg_m[i*8 +: 8] != 8'h00) &&
        (cfg_w[i*8 +: 8] != legal_cfg_value(cfg_r[i*8 +: 8], cfg_w[i*8 +: 8]))) begin
      m[5] = 1'b1;
    end
    if (last_cfg[i*8 + 7] && ((cfg_r[i*8 +: 8] != last_cfg[i*8 +: 8]) ||
        (addr_r[i*32 +: 32] != last_addr[i*32 +: 32]))) begin
      m[6] = 1'b1;
    end
  end
  return m;
endfunction

`endif

// File: verification/tb_pmp_rvfi_checker.sv
// Testbench for the PMP retire-trace checker
// Random retires from a fixed seed, expected masks and counts from a
// reference model, checked when the three-cycle output pulse arrives
`timescale 1ns/1ps
`include "pmp_checker_config.svh"

module tb_pmp_rvfi_checker;

  localparam int CLK_PERIOD  = 40;
  localparam int NUM_RETIRES = 2000;
  // Valid is high in about 4 of 5 cycles, so twice the retires is ample
  localparam int TIMEOUT     = (NUM_RETIRES * 2 + 100) * CLK_PERIOD;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            rvfi_valid_i;
  logic [31:0]                     rvfi_insn_i;
  logic [1:0]                      rvfi_mode_i;
  logic                            rvfi_trap_i;
  logic [5:0]                      rvfi_cause_i;
  logic [31:0]                     rvfi_pc_i;
  logic [31:0]                     rvfi_mem_addr_i;
  logic [`PMPC_NUM_REGIONS*8-1:0]  pmpcfg_rdata_i;
  logic [`PMPC_NUM_REGIONS*8-1:0]  pmpcfg_wdata_i;
  logic [`PMPC_NUM_REGIONS*8-1:0]  pmpcfg_wmask_i;
  logic [`PMPC_NUM_REGIONS*32-1:0] pmpaddr_rdata_i;
  logic                            viol_valid_o;
  logic [6:0]                      viol_mask_o;
  logic [`PMPC_COUNT_W-1:0]        viol_count_o;

  // Current PMP CSR contents seen by the retires
  logic [`PMPC_NUM_REGIONS*8-1:0]  cfg_state;
  logic [`PMPC_NUM_REGIONS*32-1:0] addr_state;
  // Expected {count, mask} per retire in flight
  logic [`PMPC_COUNT_W+6:0]        exp_q[$];
  logic [2:0]                      valid_hist;
  logic [`PMPC_COUNT_W-1:0]        exp_count;
  int unsigned                     check_count;
  int unsigned                     value_errors;
  int unsigned                     other_errors;

  `include "pmp_ref_model.svh"

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  pmp_rvfi_checker i_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rvfi_valid_i    (rvfi_valid_i),
    .rvfi_insn_i     (rvfi_insn_i),
    .rvfi_mode_i     (rvfi_mode_i),
    .rvfi_trap_i     (rvfi_trap_i),
    .rvfi_cause_i    (rvfi_cause_i),
    .rvfi_pc_i       (rvfi_pc_i),
    .rvfi_mem_addr_i (rvfi_mem_addr_i),
    .pmpcfg_rdata_i  (pmpcfg_rdata_i),
    .pmpcfg_wdata_i  (pmpcfg_wdata_i),
    .pmpcfg_wmask_i  (pmpcfg_wmask_i),
    .pmpaddr_rdata_i (pmpaddr_rdata_i),
    .viol_valid_o    (viol_valid_o),
    .viol_mask_o     (viol_mask_o),
    .viol_count_o    (viol_count_o)
  );

  task automatic compare_value(
    input string       name,
    input logic [31:0] actual,
    input logic [31:0] expected
  );
    check_count++;
    if (actual !== expected) begin
      value_errors++;
      $display("[FAIL] %s actual=0x%0h expected=0x%0h at %0t ns",
               name, actual, expected, $time);
    end
  endtask

  // TOR tops, NA4 words and NAPOT blocks all fall in the first 16 KB
  task automatic new_pmp_setup();
    logic [7:0]  cfg;
    logic [31:0] base;
    for (int i = 0; i < `PMPC_NUM_REGIONS; i++) begin
      base = i * 32'h400;
      cfg  = {($urandom % 100) < 15, 2'b00, 2'($urandom % 4), 3'($urandom % 8)};
      case (cfg[4:3])
        2'b01:   addr_state[i*32 +: 32] = base + 32'h200 + ($urandom % 32'h200);
        2'b11:   addr_state[i*32 +: 32] = base | ((32'h1 << ($urandom % 9)) - 1);
        default: addr_state[i*32 +: 32] = base + ($urandom % 32'h400);
      endcase
      cfg_state[i*8 +: 8] = cfg;
    end
  endtask

  function automatic logic [31:0] pick_address();
    logic [31:0] pmpaddr;
    int unsigned sel;
    sel     = $urandom % `PMPC_NUM_REGIONS;
    pmpaddr = addr_state[sel*32 +: 32];
    // Some addresses land exactly on a region boundary
    if (($urandom % 10) < 3) begin
      return {pmpaddr[29:0], 2'b00};
    end
    return $urandom % 32'h4000;
  endfunction

  function automatic logic [31:0] make_insn();
    logic [31:0] insn;
    insn = $urandom;
    case ($urandom % 5)
      0: insn[6:0] = 7'h03;
      1: insn[6:0] = 7'h23;
      2: begin
        insn[6:0]   = 7'h73;
        insn[14:12] = 3'($urandom % 7) + 3'd1;
        insn[31:20] = `PMPC_CSR_FIRST + 12'($urandom % 32'h50);
      end
      3: begin
        insn[6:0]   = 7'h73;
        insn[14:12] = 3'($urandom % 7) + 3'd1;
        insn[31:20] = 12'h300 + 12'($urandom % 32'h40);
      end
      default: insn[6:0] = 7'h33;
    endcase
    return insn;
  endfunction

  task automatic drive_retire(input bit valid);
    logic [6:0]  mask;
    logic [5:0]  good_cause;
    logic        is_m;
    logic        ld;
    logic        st;
    int unsigned j;
    rvfi_valid_i = valid;
    if (valid) begin
      // A fresh setup now and then may break a locked entry
      if (($urandom % 100) < 12) begin
        new_pmp_setup();
      end
      rvfi_insn_i     = make_insn();
      rvfi_mode_i     = ($urandom % 2) ? `PMPC_MODE_M : `PMPC_MODE_U;
      rvfi_pc_i       = pick_address();
      rvfi_mem_addr_i = pick_address();
      pmpcfg_rdata_i  = cfg_state;
      pmpaddr_rdata_i = addr_state;
      pmpcfg_wdata_i  = $urandom;
      pmpcfg_wmask_i  = '0;
      if (($urandom % 100) < 30) begin
        j = $urandom % `PMPC_NUM_REGIONS;
        pmpcfg_wmask_i[j*8 +: 8] = 8'hFF;
        if ($urandom % 2) begin
          pmpcfg_wdata_i[j*8 +: 8] = legal_cfg_value(cfg_state[j*8 +: 8], 8'($urandom));
        end
      end
      // Mostly the response a correct core gives
      is_m       = (rvfi_mode_i == `PMPC_MODE_M);
      ld         = (rvfi_insn_i[6:0] == 7'h03);
      st         = (rvfi_insn_i[6:0] == 7'h23);
      good_cause = 6'd0;
      if (!access_permitted(rvfi_pc_i, is_m, cfg_state, addr_state, 2)) begin
        good_cause = `PMPC_EXC_INSTR_ACC;
      end else if ((ld || st) &&
                   !access_permitted(rvfi_mem_addr_i, is_m, cfg_state, addr_state,
                                     st ? 1 : 0)) begin
        good_cause = st ? `PMPC_EXC_STORE_ACC : `PMPC_EXC_LOAD_ACC;
      end else if (!is_m && pmp_csr_access(rvfi_insn_i)) begin
        good_cause = `PMPC_EXC_ILL_INSTR;
      end
      rvfi_trap_i  = (good_cause != 6'd0);
      rvfi_cause_i = good_cause;
      if (($urandom % 100) < 15) begin
        rvfi_trap_i  = 1'($urandom % 2);
        rvfi_cause_i = 6'($urandom % 8);
      end
      mask = expected_mask(rvfi_insn_i, rvfi_mode_i, rvfi_trap_i, rvfi_cause_i,
                           rvfi_pc_i, rvfi_mem_addr_i, pmpcfg_rdata_i,
                           pmpcfg_wdata_i, pmpcfg_wmask_i, pmpaddr_rdata_i);
      last_cfg  = pmpcfg_rdata_i;
      last_addr = pmpaddr_rdata_i;
      if ((mask != 7'd0) && (exp_count != '1)) begin
        exp_count++;
      end
      exp_q.push_back({exp_count, mask});
    end
    valid_hist = {valid_hist[1:0], valid};
  endtask

  task automatic check_outputs();
    logic [`PMPC_COUNT_W+6:0] exp;
    // Outputs here belong to the retire driven three edges ago
    compare_value("viol_valid_o", viol_valid_o, valid_hist[2]);
    if (viol_valid_o) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("Output pulse at %0t ns with no retire in flight", $time);
      end else begin
        exp = exp_q.pop_front();
        compare_value("viol_mask_o", viol_mask_o, exp[6:0]);
        compare_value("viol_count_o", viol_count_o, exp[`PMPC_COUNT_W+6:7]);
      end
    end
    if (exp_q.size() != int'(valid_hist[0]) + int'(valid_hist[1])) begin
      other_errors++;
      $display("Retires in flight do not match the pipeline depth at %0t ns", $time);
    end
  endtask

  task automatic step_cycle(input bit valid);
    @(negedge clk_i);
    check_outputs();
    drive_retire(valid);
  endtask

  task automatic run_retires(input int unsigned count);
    int unsigned done_count;
    bit          valid;
    done_count = 0;
    while (done_count < count) begin
      valid = ($urandom % 100) < 80;
      step_cycle(valid);
      if (valid) begin
        done_count++;
      end
    end
    // Let the last retires leave the three stages
    repeat (4) step_cycle(1'b0);
  endtask

  task automatic reset_mid_run();
    @(negedge clk_i);
    rst_ni = 1'b0;
    @(negedge clk_i);
    compare_value("viol_count_o", viol_count_o, 32'd0);
    @(negedge clk_i);
    rst_ni    = 1'b1;
    exp_count = '0;
    last_cfg  = '0;
    last_addr = '0;
  endtask

  initial begin
    void'($urandom(32'h3f18));
    rst_ni          = 1'b0;
    rvfi_valid_i    = 1'b0;
    rvfi_insn_i     = '0;
    rvfi_mode_i     = '0;
    rvfi_trap_i     = 1'b0;
    rvfi_cause_i    = '0;
    rvfi_pc_i       = '0;
    rvfi_mem_addr_i = '0;
    pmpcfg_rdata_i  = '0;
    pmpcfg_wdata_i  = '0;
    pmpcfg_wmask_i  = '0;
    pmpaddr_rdata_i = '0;
    valid_hist      = '0;
    exp_count       = '0;
    last_cfg        = '0;
    last_addr       = '0;
    check_count     = 0;
    value_errors    = 0;
    other_errors    = 0;
    new_pmp_setup();
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    run_retires(NUM_RETIRES / 2);
    reset_mid_run();
    run_retires(NUM_RETIRES - NUM_RETIRES / 2);
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("%0d expected results never came out", exp_q.size());
    end
    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             check_count, value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT);
    $display("Timeout after %0d ns, the run did not finish", TIMEOUT);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: rtl/pmp_rvfi_checker.sv
// PMP retire-trace checker top level
// Decode, region match and rule check as three registered stages,
// a violation mask appears three cycles after each retire
`timescale 1ns/1ps

module pmp_rvfi_checker (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           rvfi_valid_i,
  input  pmp_checker_pkg::word_t         rvfi_insn_i,
  input  pmp_checker_pkg::mode_t         rvfi_mode_i,
  input  logic                           rvfi_trap_i,
  input  pmp_checker_pkg::cause_t        rvfi_cause_i,
  input  pmp_checker_pkg::word_t         rvfi_pc_i,
  input  pmp_checker_pkg::word_t         rvfi_mem_addr_i,
  input  pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_rdata_i,
  input  pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_wdata_i,
  input  pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_wmask_i,
  input  pmp_checker_pkg::pmp_addr_vec_t pmpaddr_rdata_i,
  output logic                           viol_valid_o,
  output pmp_checker_pkg::viol_mask_t    viol_mask_o,
  output pmp_checker_pkg::count_t        viol_count_o
);

  // Decode to match
  logic                           valid_d;
  pmp_checker_pkg::word_t         insn_d;
  pmp_checker_pkg::mode_t         mode_d;
  logic                           trap_d;
  pmp_checker_pkg::cause_t        cause_d;
  pmp_checker_pkg::word_t         pc_d;
  pmp_checker_pkg::word_t         mem_addr_d;
  pmp_checker_pkg::pmp_cfg_vec_t  cfg_rdata_d;
  pmp_checker_pkg::pmp_cfg_vec_t  cfg_wdata_d;
  pmp_checker_pkg::pmp_cfg_vec_t  cfg_wmask_d;
  pmp_checker_pkg::pmp_addr_vec_t addr_rdata_d;
  logic                           pmp_csr_d;
  logic                           is_load_d;
  logic                           is_store_d;

  // Match to check
  logic                           valid_m;
  pmp_checker_pkg::mode_t         mode_m;
  logic                           trap_m;
  pmp_checker_pkg::cause_t        cause_m;
  pmp_checker_pkg::pmp_cfg_vec_t  cfg_rdata_m;
  pmp_checker_pkg::pmp_cfg_vec_t  cfg_wdata_m;
  pmp_checker_pkg::pmp_cfg_vec_t  cfg_wmask_m;
  pmp_checker_pkg::pmp_addr_vec_t addr_rdata_m;
  logic                           pmp_csr_m;
  logic                           is_load_m;
  logic                           is_store_m;
  logic                           fetch_allowed_m;
  logic                           data_allowed_m;

  rvfi_decode_stage i_decode (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rvfi_valid_i      (rvfi_valid_i),
    .rvfi_insn_i       (rvfi_insn_i),
    .rvfi_mode_i       (rvfi_mode_i),
    .rvfi_trap_i       (rvfi_trap_i),
    .rvfi_cause_i      (rvfi_cause_i),
    .rvfi_pc_i         (rvfi_pc_i),
    .rvfi_mem_addr_i   (rvfi_mem_addr_i),
    .pmpcfg_rdata_i    (pmpcfg_rdata_i),
    .pmpcfg_wdata_i    (pmpcfg_wdata_i),
    .pmpcfg_wmask_i    (pmpcfg_wmask_i),
    .pmpaddr_rdata_i   (pmpaddr_rdata_i),
    .valid_d_o         (valid_d),
    .insn_d_o          (insn_d),
    .mode_d_o          (mode_d),
    .trap_d_o          (trap_d),
    .cause_d_o         (cause_d),
    .pc_d_o            (pc_d),
    .mem_addr_d_o      (mem_addr_d),
    .pmpcfg_rdata_d_o  (cfg_rdata_d),
    .pmpcfg_wdata_d_o  (cfg_wdata_d),
    .pmpcfg_wmask_d_o  (cfg_wmask_d),
    .pmpaddr_rdata_d_o (addr_rdata_d),
    .pmp_csr_o         (pmp_csr_d),
    .is_load_o         (is_load_d),
    .is_store_o        (is_store_d)
  );

  pmp_match_stage i_match (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .valid_d_i         (valid_d),
    .insn_d_i          (insn_d),
    .mode_d_i          (mode_d),
    .trap_d_i          (trap_d),
    .cause_d_i         (cause_d),
    .pc_d_i            (pc_d),
    .mem_addr_d_i      (mem_addr_d),
    .pmpcfg_rdata_d_i  (cfg_rdata_d),
    .pmpcfg_wdata_d_i  (cfg_wdata_d),
    .pmpcfg_wmask_d_i  (cfg_wmask_d),
    .pmpaddr_rdata_d_i (addr_rdata_d),
    .pmp_csr_d_i       (pmp_csr_d),
    .is_load_d_i       (is_load_d),
    .is_store_d_i      (is_store_d),
    .valid_m_o         (valid_m),
    .mode_m_o          (mode_m),
    .trap_m_o          (trap_m),
    .cause_m_o         (cause_m),
    .pmpcfg_rdata_m_o  (cfg_rdata_m),
    .pmpcfg_wdata_m_o  (cfg_wdata_m),
    .pmpcfg_wmask_m_o  (cfg_wmask_m),
    .pmpaddr_rdata_m_o (addr_rdata_m),
    .pmp_csr_m_o       (pmp_csr_m),
    .is_load_m_o       (is_load_m),
    .is_store_m_o      (is_store_m),
    .fetch_allowed_o   (fetch_allowed_m),
    .data_allowed_o    (data_allowed_m)
  );

  violation_check_stage i_check (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .valid_m_i         (valid_m),
    .mode_m_i          (mode_m),
    .trap_m_i          (trap_m),
    .cause_m_i         (cause_m),
    .pmpcfg_rdata_m_i  (cfg_rdata_m),
    .pmpcfg_wdata_m_i  (cfg_wdata_m),
    .pmpcfg_wmask_m_i  (cfg_wmask_m),
    .pmpaddr_rdata_m_i (addr_rdata_m),
    .pmp_csr_m_i       (pmp_csr_m),
    .is_load_m_i       (is_load_m),
    .is_store_m_i      (is_store_m),
    .fetch_allowed_m_i (fetch_allowed_m),
    .data_allowed_m_i  (data_allowed_m),
    .viol_valid_o      (viol_valid_o),
    .viol_mask_o       (viol_mask_o),
    .viol_count_o      (viol_count_o)
  );

endmodule

// File: rtl/violation_check_stage.sv
// Third checker stage
// Evaluates the seven PMP rules for one retire, keeps the cfg and
// address history for the lock rule and counts violating retires
`timescale 1ns/1ps
`include "pmp_checker_config.svh"

module violation_check_stage (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           valid_m_i,
  input  pmp_checker_pkg::mode_t         mode_m_i,
  input  logic                           trap_m_i,
  input  pmp_checker_pkg::cause_t        cause_m_i,
  input  pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_rdata_m_i,
  input  pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_wdata_m_i,
  input  pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_wmask_m_i,
  input  pmp_checker_pkg::pmp_addr_vec_t pmpaddr_rdata_m_i,
  input  logic                           pmp_csr_m_i,
  input  logic                           is_load_m_i,
  input  logic                           is_store_m_i,
  input  logic                           fetch_allowed_m_i,
  input  logic                           data_allowed_m_i,
  output logic                           viol_valid_o,
  output pmp_checker_pkg::viol_mask_t    viol_mask_o,
  output pmp_checker_pkg::count_t        viol_count_o
);

  pmp_checker_pkg::viol_mask_t    mask;
  pmp_checker_pkg::pmp_cfg_vec_t  prev_cfg_q;
  pmp_checker_pkg::pmp_addr_vec_t prev_addr_q;
  pmp_checker_pkg::cause_t        data_cause;
  logic                           data_denied;
  logic                           cfg_illegal;
  logic                           lock_changed;

  assign data_denied = (is_load_m_i || is_store_m_i) && !data_allowed_m_i;
  assign data_cause  = is_load_m_i ? `PMPC_EXC_LOAD_ACC : `PMPC_EXC_STORE_ACC;

  always_comb begin
    cfg_illegal  = 1'b0;
    lock_changed = 1'b0;
    for (int i = 0; i < `PMPC_NUM_REGIONS; i++) begin
      if ((pmpcfg_wmask_m_i[i*8 +: 8] != 8'h00) &&
          (pmpcfg_wdata_m_i[i*8 +: 8] !=
           pmp_checker_pkg::legalize_cfg(pmpcfg_rdata_m_i[i*8 +: 8],
                                         pmpcfg_wdata_m_i[i*8 +: 8]))) begin
        cfg_illegal = 1'b1;
      end
      // Entry locked at the previous retire must not move
      if (prev_cfg_q[i*8 + 7] &&
          ((pmpcfg_rdata_m_i[i*8 +: 8] != prev_cfg_q[i*8 +: 8]) ||
           (pmpaddr_rdata_m_i[i*32 +: 32] != prev_addr_q[i*32 +: 32]))) begin
        lock_changed = 1'b1;
      end
    end
  end

  always_comb begin
    mask[0] = pmp_csr_m_i && (mode_m_i == `PMPC_MODE_U) &&
              !(trap_m_i && (cause_m_i == `PMPC_EXC_ILL_INSTR));
    mask[1] = !fetch_allowed_m_i && !trap_m_i;
    mask[2] = !fetch_allowed_m_i && trap_m_i && (cause_m_i != `PMPC_EXC_INSTR_ACC);
    mask[3] = data_denied && !trap_m_i;
    mask[4] = data_denied && trap_m_i && (cause_m_i != data_cause);
    mask[5] = cfg_illegal;
    mask[6] = lock_changed;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      viol_valid_o <= 1'b0;
      viol_mask_o  <= '0;
      viol_count_o <= '0;
      prev_cfg_q   <= '0;
    end else begin
      viol_valid_o <= valid_m_i;
      viol_mask_o  <= valid_m_i ? mask : '0;
      if (valid_m_i) begin
        prev_cfg_q <= pmpcfg_rdata_m_i;
        // Saturating count of violating retires
        if ((mask != '0) && (viol_count_o != '1)) begin
          viol_count_o <= viol_count_o + 1'b1;
        end
      end
    end
  end

  // Only read behind a set L bit in prev_cfg_q
  always_ff @(posedge clk_i) begin
    if (valid_m_i) begin
      prev_addr_q <= pmpaddr_rdata_m_i;
    end
  end

  a_count_monotonic: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    viol_count_o >= $past(viol_count_o)
  );

endmodule

// File: rtl/pmp_match_stage.sv
// Second checker stage
// Matches the PC and the memory address against the PMP regions,
// first match wins, and decides fetch and data permission
`timescale 1ns/1ps
`include "pmp_checker_config.svh"

module pmp_match_stage (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           valid_d_i,
  input  pmp_checker_pkg::word_t         insn_d_i,
  input  pmp_checker_pkg::mode_t         mode_d_i,
  input  logic                           trap_d_i,
  input  pmp_checker_pkg::cause_t        cause_d_i,
  input  pmp_checker_pkg::word_t         pc_d_i,
  input  pmp_checker_pkg::word_t         mem_addr_d_i,
  input  pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_rdata_d_i,
  input  pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_wdata_d_i,
  input  pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_wmask_d_i,
  input  pmp_checker_pkg::pmp_addr_vec_t pmpaddr_rdata_d_i,
  input  logic                           pmp_csr_d_i,
  input  logic                           is_load_d_i,
  input  logic                           is_store_d_i,
  output logic                           valid_m_o,
  output pmp_checker_pkg::mode_t         mode_m_o,
  output logic                           trap_m_o,
  output pmp_checker_pkg::cause_t        cause_m_o,
  output pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_rdata_m_o,
  output pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_wdata_m_o,
  output pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_wmask_m_o,
  output pmp_checker_pkg::pmp_addr_vec_t pmpaddr_rdata_m_o,
  output logic                           pmp_csr_m_o,
  output logic                           is_load_m_o,
  output logic                           is_store_m_o,
  output logic                           fetch_allowed_o,
  output logic                           data_allowed_o
);

  // Permission of one access, perm selects X, W or R in the cfg byte
  function automatic logic access_allowed(
    input pmp_checker_pkg::word_t        addr,
    input pmp_checker_pkg::mode_t        mode,
    input pmp_checker_pkg::pmp_cfg_vec_t cfg_vec,
    input pmp_checker_pkg::pmp_addr_vec_t addr_vec,
    input int unsigned                   perm
  );
    pmp_checker_pkg::word_t    word_addr;
    pmp_checker_pkg::word_t    lo;
    pmp_checker_pkg::word_t    hi;
    pmp_checker_pkg::word_t    napot_mask;
    pmp_checker_pkg::pmp_cfg_t cfg;
    logic                      hit;
    logic                      found;
    logic                      allowed;
    // Zero-extended address, bits 33:2
    word_addr = {2'b00, addr[31:2]};
    lo        = '0;
    found     = 1'b0;
    // No match allows in M-mode and denies otherwise
    allowed   = (mode == `PMPC_MODE_M);
    for (int i = 0; i < `PMPC_NUM_REGIONS; i++) begin
      cfg = cfg_vec[i*8 +: 8];
      hi  = addr_vec[i*32 +: 32];
      // Trailing ones and the zero above them form the NAPOT offset
      napot_mask = ~(hi ^ (hi + 32'd1));
      case (cfg[4:3])
        2'b01:   hit = (word_addr >= lo) && (word_addr < hi);
        2'b10:   hit = (word_addr == hi);
        2'b11:   hit = ((word_addr & napot_mask) == (hi & napot_mask));
        default: hit = 1'b0;
      endcase
      if (hit && !found) begin
        found = 1'b1;
        if (mode == `PMPC_MODE_M) begin
          allowed = !cfg[7] || cfg[perm];
        end else begin
          allowed = cfg[perm];
        end
      end
      lo = hi;
    end
    return allowed;
  endfunction

  logic        fetch_allowed;
  logic        data_allowed;
  int unsigned data_perm;

  // Store opcodes have bit 5 set, loads need R
  assign data_perm     = insn_d_i[5] ? 1 : 0;
  assign fetch_allowed = access_allowed(pc_d_i, mode_d_i, pmpcfg_rdata_d_i,
                                        pmpaddr_rdata_d_i, 2);
  assign data_allowed  = access_allowed(mem_addr_d_i, mode_d_i, pmpcfg_rdata_d_i,
                                        pmpaddr_rdata_d_i, data_perm);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_m_o    <= 1'b0;
      pmp_csr_m_o  <= 1'b0;
      is_load_m_o  <= 1'b0;
      is_store_m_o <= 1'b0;
    end else begin
      valid_m_o    <= valid_d_i;
      pmp_csr_m_o  <= valid_d_i && pmp_csr_d_i;
      is_load_m_o  <= valid_d_i && is_load_d_i;
      is_store_m_o <= valid_d_i && is_store_d_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_d_i) begin
      mode_m_o          <= mode_d_i;
      trap_m_o          <= trap_d_i;
      cause_m_o         <= cause_d_i;
      pmpcfg_rdata_m_o  <= pmpcfg_rdata_d_i;
      pmpcfg_wdata_m_o  <= pmpcfg_wdata_d_i;
      pmpcfg_wmask_m_o  <= pmpcfg_wmask_d_i;
      pmpaddr_rdata_m_o <= pmpaddr_rdata_d_i;
      fetch_allowed_o   <= fetch_allowed;
      data_allowed_o    <= data_allowed;
    end
  end

  a_valid_one_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    valid_m_o == $past(valid_d_i)
  );

endmodule

// File: rtl/rvfi_decode_stage.sv
// First checker stage
// Registers one retired instruction and classifies it as a PMP CSR
// access, a load or a store
`timescale 1ns/1ps
`include "pmp_checker_config.svh"

module rvfi_decode_stage (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           rvfi_valid_i,
  input  pmp_checker_pkg::word_t         rvfi_insn_i,
  input  pmp_checker_pkg::mode_t         rvfi_mode_i,
  input  logic                           rvfi_trap_i,
  input  pmp_checker_pkg::cause_t        rvfi_cause_i,
  input  pmp_checker_pkg::word_t         rvfi_pc_i,
  input  pmp_checker_pkg::word_t         rvfi_mem_addr_i,
  input  pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_rdata_i,
  input  pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_wdata_i,
  input  pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_wmask_i,
  input  pmp_checker_pkg::pmp_addr_vec_t pmpaddr_rdata_i,
  output logic                           valid_d_o,
  output pmp_checker_pkg::word_t         insn_d_o,
  output pmp_checker_pkg::mode_t         mode_d_o,
  output logic                           trap_d_o,
  output pmp_checker_pkg::cause_t        cause_d_o,
  output pmp_checker_pkg::word_t         pc_d_o,
  output pmp_checker_pkg::word_t         mem_addr_d_o,
  output pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_rdata_d_o,
  output pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_wdata_d_o,
  output pmp_checker_pkg::pmp_cfg_vec_t  pmpcfg_wmask_d_o,
  output pmp_checker_pkg::pmp_addr_vec_t pmpaddr_rdata_d_o,
  output logic                           pmp_csr_o,
  output logic                           is_load_o,
  output logic                           is_store_o
);

  logic [6:0]  opcode;
  logic [11:0] csr_addr;
  logic        csr_access;
  logic        pmp_window;

  assign opcode   = rvfi_insn_i[6:0];
  assign csr_addr = rvfi_insn_i[31:20];

  // SYSTEM opcode with nonzero funct3 is a Zicsr instruction
  assign csr_access = (opcode == 7'b1110011) && (rvfi_insn_i[14:12] != 3'b000);
  assign pmp_window = (csr_addr >= `PMPC_CSR_FIRST) && (csr_addr <= `PMPC_CSR_LAST);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_d_o  <= 1'b0;
      pmp_csr_o  <= 1'b0;
      is_load_o  <= 1'b0;
      is_store_o <= 1'b0;
    end else begin
      valid_d_o  <= rvfi_valid_i;
      pmp_csr_o  <= rvfi_valid_i && csr_access && pmp_window;
      is_load_o  <= rvfi_valid_i && (opcode == 7'b0000011);
      is_store_o <= rvfi_valid_i && (opcode == 7'b0100011);
    end
  end

  // Retire payload, captured only for valid retires
  always_ff @(posedge clk_i) begin
    if (rvfi_valid_i) begin
      insn_d_o          <= rvfi_insn_i;
      mode_d_o          <= rvfi_mode_i;
      trap_d_o          <= rvfi_trap_i;
      cause_d_o         <= rvfi_cause_i;
      pc_d_o            <= rvfi_pc_i;
      mem_addr_d_o      <= rvfi_mem_addr_i;
      pmpcfg_rdata_d_o  <= pmpcfg_rdata_i;
      pmpcfg_wdata_d_o  <= pmpcfg_wdata_i;
      pmpcfg_wmask_d_o  <= pmpcfg_wmask_i;
      pmpaddr_rdata_d_o <= pmpaddr_rdata_i;
    end
  end

  a_load_store_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(is_load_o && is_store_o)
  );

endmodule

// File: rtl/pmp_checker_pkg.sv
// PMP retire-trace checker types
// Vector types for retire fields and PMP CSR values, and the
// pmpcfg write legalization rule shared by the checker stages
`include "pmp_checker_config.svh"

package pmp_checker_pkg;

  typedef logic [31:0] word_t;
  typedef logic [1:0]  mode_t;
  typedef logic [5:0]  cause_t;

  // L in bit 7, A in bits 4:3, then X, W, R
  typedef logic [7:0] pmp_cfg_t;

  // Region i sits in byte i
  typedef logic [`PMPC_NUM_REGIONS*8-1:0] pmp_cfg_vec_t;

  // Each word holds physical address bits 33:2
  typedef logic [`PMPC_NUM_REGIONS*32-1:0] pmp_addr_vec_t;

  // csr_umode, exec_no_trap, exec_cause, data_no_trap,
  // data_cause, cfg_illegal, lock_changed (bit 0 upward)
  typedef logic [6:0] viol_mask_t;

  typedef logic [`PMPC_COUNT_W-1:0] count_t;

  // Legal result of writing attempt_cfg over prev_cfg
  function automatic pmp_cfg_t legalize_cfg(
    input pmp_cfg_t prev_cfg,
    input pmp_cfg_t attempt_cfg
  );
    pmp_cfg_t result;
    result = attempt_cfg;
    // RWX 010 and 110 are reserved
    if ((attempt_cfg[2:0] == 3'b010) || (attempt_cfg[2:0] == 3'b110)) begin
      result[2:0] = prev_cfg[2:0];
    end
    // Locked entry ignores the write
    if (prev_cfg[7]) begin
      result = prev_cfg;
    end
    result[6:5] = 2'b00;
    return result;
  endfunction

endpackage

// File: rtl/pmp_checker_config.svh
// PMP retire-trace checker configuration
// Region count, CSR addresses, privilege modes and exception causes
`ifndef PMP_CHECKER_CONFIG_SVH
`define PMP_CHECKER_CONFIG_SVH

// Number of PMP regions checked
`define PMPC_NUM_REGIONS 4

// CSR addresses
`define PMPC_CSR_PMPCFG0 12'h3A0
`define PMPC_CSR_FIRST   12'h3A0
`define PMPC_CSR_LAST    12'h3EF

// Privilege modes
`define PMPC_MODE_U 2'd0
`define PMPC_MODE_M 2'd3

// Exception causes
`define PMPC_EXC_INSTR_ACC 6'd1
`define PMPC_EXC_ILL_INSTR 6'd2
`define PMPC_EXC_LOAD_ACC  6'd5
`define PMPC_EXC_STORE_ACC 6'd7

// Violation counter width
`define PMPC_COUNT_W 16

`endif
